// ==== alu_fault_pkg.sv ====
// ALU fault tracker shared package: opcodes, class indices, payload structs, CSR map
package alu_fault_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////
  localparam int unsigned NUM_CLASSES    = 9;
  localparam int unsigned CNT_WIDTH      = 32;
  localparam int unsigned CSR_ADDR_WIDTH = 12;

  // Operator codes, a subset per class
  // Codes not listed here fall in no class
  typedef enum logic [6:0] {
    // Comparison
    ALU_LTS   = 7'b0000000,
    ALU_LTU   = 7'b0000001,
    ALU_EQ    = 7'b0001100,
    ALU_NE    = 7'b0001101,
    // Min/max
    ALU_MIN   = 7'b0010000,
    ALU_MINU  = 7'b0010001,
    ALU_MAX   = 7'b0010010,
    ALU_MAXU  = 7'b0010011,
    // Abs/clip
    ALU_ABS   = 7'b0010100,
    ALU_CLIP  = 7'b0010110,
    ALU_CLIPU = 7'b0010111,
    // Logic
    ALU_AND   = 7'b0010101,
    ALU_OR    = 7'b0101110,
    ALU_XOR   = 7'b0101111,
    // Add/shift
    ALU_ADD   = 7'b0011000,
    ALU_SUB   = 7'b0011001,
    ALU_SRA   = 7'b0100100,
    ALU_SLL   = 7'b0100111,
    // Bit manipulation
    ALU_BEXT  = 7'b0101000,
    ALU_BINS  = 7'b0101010,
    ALU_BCLR  = 7'b0101011,
    ALU_BSET  = 7'b0101100,
    // Bit counting
    ALU_CNT   = 7'b0110100,
    ALU_CLB   = 7'b0110101,
    ALU_FF1   = 7'b0110110,
    ALU_FL1   = 7'b0110111,
    // Shuffle
    ALU_INS   = 7'b0101101,
    ALU_PCKLO = 7'b0111000,
    ALU_SHUF  = 7'b0111010,
    ALU_EXT   = 7'b0111111,
    // Div/rem
    ALU_DIVU  = 7'b0110000,
    ALU_DIV   = 7'b0110001,
    ALU_REMU  = 7'b0110010,
    ALU_REM   = 7'b0110011
  } alu_op_t;

  // Class index, also bit position in the class mask
  typedef enum logic [3:0] {
    CLASS_ADD   = 4'd0,
    CLASS_LOGIC = 4'd1,
    CLASS_BMAN  = 4'd2,
    CLASS_BCNT  = 4'd3,
    CLASS_SHUF  = 4'd4,
    CLASS_CMP   = 4'd5,
    CLASS_ABS   = 4'd6,
    CLASS_MMAX  = 4'd7,
    CLASS_DIV   = 4'd8
  } op_class_e;

  typedef logic [NUM_CLASSES-1:0] class_mask_t;
  typedef logic [CNT_WIDTH-1:0]   cnt_t;

  //////////////////////////////
  // Payload structs
  //////////////////////////////
  // One ALU, one cycle
  typedef struct packed {
    logic    enable;
    alu_op_t op;
    logic    error;
  } alu_obs_t;

  // CSR access
  typedef struct packed {
    logic [CSR_ADDR_WIDTH-1:0] addr;
    logic                      re;
    logic                      we;
    cnt_t                      wdata;
  } csr_req_t;

  // Counter of ALU a, class c at base + 4*c + a
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_CNT_BASE = 12'h7C0;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_FMAP_LO  = CSR_CNT_BASE + 12'd36;
  localparam logic [CSR_ADDR_WIDTH-1:0] CSR_FMAP_HI  = CSR_CNT_BASE + 12'd37;

  // At or below this a clean op clears the counter
  localparam cnt_t FLOOR = 32'd2;

endpackage

// ==== alu_op_classifier.sv ====
// Operator classifier: maps an ALU operator code onto a one-hot functional class mask
`timescale 1ns/1ps

module alu_op_classifier
  import alu_fault_pkg::*;
(
  input  alu_op_t     op_i,
  output class_mask_t class_o
);

  always_comb begin
    // Unlisted codes leave the mask empty
    class_o = '0;
    unique case (op_i)
      // Add/shift
      ALU_ADD, ALU_SUB, ALU_SRA, ALU_SLL:
        class_o[CLASS_ADD] = 1'b1;
      // Logic
      ALU_XOR, ALU_OR, ALU_AND:
        class_o[CLASS_LOGIC] = 1'b1;
      // Bit manipulation
      ALU_BEXT, ALU_BINS, ALU_BCLR, ALU_BSET:
        class_o[CLASS_BMAN] = 1'b1;
      // Bit counting
      ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB:
        class_o[CLASS_BCNT] = 1'b1;
      // Shuffle and pack
      ALU_EXT, ALU_SHUF, ALU_PCKLO, ALU_INS:
        class_o[CLASS_SHUF] = 1'b1;
      // Compare
      ALU_LTS, ALU_LTU, ALU_EQ, ALU_NE:
        class_o[CLASS_CMP] = 1'b1;
      // Abs and clip
      ALU_ABS, ALU_CLIP, ALU_CLIPU:
        class_o[CLASS_ABS] = 1'b1;
      // Min/max
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU:
        class_o[CLASS_MMAX] = 1'b1;
      // Divider ops
      ALU_DIVU, ALU_DIV, ALU_REMU, ALU_REM:
        class_o[CLASS_DIV] = 1'b1;
      default: begin
        class_o = '0;
      end
    endcase
  end

endmodule

// ==== subunit_err_counter.sv ====
// Leaky error counter with sticky permanent-fault flag for one ALU functional class
`timescale 1ns/1ps

module subunit_err_counter
  import alu_fault_pkg::*;
#(
  parameter int unsigned ERR_THRESHOLD = 16,
  parameter int unsigned ERR_INCREASE  = 2,
  parameter int unsigned ERR_DECREASE  = 1
) (
  input  logic clock_gated,
  input  logic rst_n,
  input  logic event_i,
  input  logic error_i,
  input  logic cnt_we_i,
  input  cnt_t cnt_wdata_i,
  input  logic flag_set_i,
  output cnt_t count_o,
  output logic faulty_o
);

  cnt_t cnt_q, cnt_d;
  logic flag_q, flag_d;
  logic at_threshold;

  // Compared against the count before this edge
  assign at_threshold = (cnt_q >= cnt_t'(ERR_THRESHOLD));

  //////////////////////////////
  // Next count
  //////////////////////////////
  always_comb begin
    cnt_d = cnt_q;
    if (cnt_we_i) begin
      // Software write wins
      cnt_d = cnt_wdata_i;
    end else if (flag_q) begin
      // Faulty class parks at zero
      cnt_d = '0;
    end else if (event_i) begin
      if (error_i) begin
        cnt_d = cnt_q + cnt_t'(ERR_INCREASE);
      end else if (cnt_q > FLOOR) begin
        cnt_d = cnt_q - cnt_t'(ERR_DECREASE);
      end else begin
        // Drain floor reached
        cnt_d = '0;
      end
    end
  end

  // Sticky until reset
  assign flag_d = flag_q | flag_set_i | (event_i & at_threshold);

  always_ff @(posedge clock_gated or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      flag_q <= 1'b0;
    end else begin
      cnt_q  <= cnt_d;
      flag_q <= flag_d;
    end
  end

  assign count_o  = cnt_q;
  assign faulty_o = flag_q;

endmodule

// ==== alu_health_monitor.sv ====
// Health monitor for one ALU: classifies each op and steers it to nine class counters
`timescale 1ns/1ps

module alu_health_monitor
  import alu_fault_pkg::*;
#(
  parameter int unsigned ERR_THRESHOLD = 16,
  parameter int unsigned ERR_INCREASE  = 2,
  parameter int unsigned ERR_DECREASE  = 1
) (
  input  logic                   clock_gated,
  input  logic                   rst_n,
  input  alu_obs_t               obs_i,
  input  logic                   div_ready_i,
  input  class_mask_t            cnt_we_i,
  input  cnt_t                   cnt_wdata_i,
  input  class_mask_t            flag_set_i,
  output cnt_t [NUM_CLASSES-1:0] counts_o,
  output class_mask_t            faulty_o
);

  class_mask_t op_class;
  class_mask_t class_event;

  //////////////////////////////
  // Operator decode
  //////////////////////////////
  alu_op_classifier u_classifier (
    .op_i    (obs_i.op),
    .class_o (op_class)
  );

  // Strobe qualifies the class hit
  always_comb begin
    class_event = op_class & {NUM_CLASSES{obs_i.enable}};
    // Multi-cycle divider only counts once its result is out
    class_event[CLASS_DIV] = class_event[CLASS_DIV] & div_ready_i;
  end

  //////////////////////////////
  // Class counters
  //////////////////////////////
  for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_class
    // Error bit shared by all classes of this ALU
    subunit_err_counter #(
      .ERR_THRESHOLD (ERR_THRESHOLD),
      .ERR_INCREASE  (ERR_INCREASE),
      .ERR_DECREASE  (ERR_DECREASE)
    ) u_counter (
      .clock_gated (clock_gated),
      .rst_n       (rst_n),
      .event_i     (class_event[c]),
      .error_i     (obs_i.error),
      .cnt_we_i    (cnt_we_i[c]),
      .cnt_wdata_i (cnt_wdata_i),
      .flag_set_i  (flag_set_i[c]),
      .count_o     (counts_o[c]),
      .faulty_o    (faulty_o[c])
    );
  end

endmodule

// ==== fault_csr_bank.sv ====
// CSR bank for the fault tracker: address decode, read mux, write strobes, fault-map packing
`timescale 1ns/1ps

module fault_csr_bank
  import alu_fault_pkg::*;
#(
  parameter int unsigned NUM_ALUS = 4
) (
  input  csr_req_t                               csr_req_i,
  input  cnt_t [NUM_ALUS-1:0][NUM_CLASSES-1:0]   counts_i,
  input  class_mask_t [NUM_ALUS-1:0]             faulty_i,
  output cnt_t                                   csr_rdata_o,
  output class_mask_t [NUM_ALUS-1:0]             cnt_we_o,
  output cnt_t                                   cnt_wdata_o,
  output class_mask_t [NUM_ALUS-1:0]             flag_set_o
);

  // Counter window is 4 ALU slots per class
  localparam logic [CSR_ADDR_WIDTH-1:0] CNT_SPAN = CSR_ADDR_WIDTH'(4 * NUM_CLASSES);

  logic [CSR_ADDR_WIDTH-1:0] offset;
  logic [1:0]                alu_idx;
  logic [3:0]                cls_idx;
  logic                      cnt_hit;
  logic                      lo_hit;
  logic                      hi_hit;
  logic                      wr_en;
  cnt_t                      fmap_lo;
  cnt_t                      fmap_hi;

  //////////////////////////////
  // Address decode
  //////////////////////////////
  // Below base wraps high, so one compare covers both ends
  assign offset  = csr_req_i.addr - CSR_CNT_BASE;
  assign alu_idx = offset[1:0];
  assign cls_idx = offset[5:2];
  assign cnt_hit = (offset < CNT_SPAN) && (32'(alu_idx) < NUM_ALUS);
  assign lo_hit  = (csr_req_i.addr == CSR_FMAP_LO);
  assign hi_hit  = (csr_req_i.addr == CSR_FMAP_HI);

  // Read wins over write
  assign wr_en = csr_req_i.we & ~csr_req_i.re;

  //////////////////////////////
  // Fault map packing
  //////////////////////////////
  always_comb begin
    fmap_lo = '0;
    fmap_hi = '0;
    for (int a = 0; a < NUM_ALUS; a++) begin
      // Classes 0..7 interleaved by ALU
      for (int c = 0; c < NUM_CLASSES - 1; c++) begin
        fmap_lo[4*c + a] = faulty_i[a][c];
      end
      // Div/rem in the low nibble
      fmap_hi[a] = faulty_i[a][CLASS_DIV];
    end
  end

  // Read mux, zero when idle or unmapped
  always_comb begin
    csr_rdata_o = '0;
    if (csr_req_i.re) begin
      if (cnt_hit) begin
        csr_rdata_o = counts_i[alu_idx][cls_idx];
      end else if (lo_hit) begin
        csr_rdata_o = fmap_lo;
      end else if (hi_hit) begin
        csr_rdata_o = fmap_hi;
      end
    end
  end

  //////////////////////////////
  // Write strobes
  //////////////////////////////
  always_comb begin
    cnt_we_o   = '0;
    flag_set_o = '0;
    if (wr_en && cnt_hit) begin
      cnt_we_o[alu_idx][cls_idx] = 1'b1;
    end
    for (int a = 0; a < NUM_ALUS; a++) begin
      // Map writes only set flags, zeros are ignored
      for (int c = 0; c < NUM_CLASSES - 1; c++) begin
        flag_set_o[a][c] = wr_en & lo_hit & csr_req_i.wdata[4*c + a];
      end
      flag_set_o[a][CLASS_DIV] = wr_en & hi_hit & csr_req_i.wdata[a];
    end
  end

  // Shared by every counter, the strobe picks one
  assign cnt_wdata_o = csr_req_i.wdata;

endmodule

// ==== alu_fault_tracker.sv ====
// ALU fault tracker top: per-ALU health monitors joined to the CSR bank
`timescale 1ns/1ps

module alu_fault_tracker
  import alu_fault_pkg::*;
#(
  parameter int unsigned NUM_ALUS      = 4,
  parameter int unsigned ERR_THRESHOLD = 16,
  parameter int unsigned ERR_INCREASE  = 2,
  parameter int unsigned ERR_DECREASE  = 1
) (
  input  logic                       clock_gated,
  input  logic                       rst_n,
  input  alu_obs_t [NUM_ALUS-1:0]    alu_obs_i,
  input  logic                       div_ready_i,
  input  csr_req_t                   csr_req_i,
  output cnt_t                       csr_rdata_o,
  output class_mask_t [NUM_ALUS-1:0] fault_map_o
);

  cnt_t [NUM_ALUS-1:0][NUM_CLASSES-1:0] counts;
  class_mask_t [NUM_ALUS-1:0]           cnt_we;
  class_mask_t [NUM_ALUS-1:0]           flag_set;
  cnt_t                                 cnt_wdata;

  //////////////////////////////
  // One monitor per ALU
  //////////////////////////////
  for (genvar a = 0; a < NUM_ALUS; a++) begin : g_alu
    alu_health_monitor #(
      .ERR_THRESHOLD (ERR_THRESHOLD),
      .ERR_INCREASE  (ERR_INCREASE),
      .ERR_DECREASE  (ERR_DECREASE)
    ) u_monitor (
      .clock_gated (clock_gated),
      .rst_n       (rst_n),
      .obs_i       (alu_obs_i[a]),
      .div_ready_i (div_ready_i),
      .cnt_we_i    (cnt_we[a]),
      .cnt_wdata_i (cnt_wdata),
      .flag_set_i  (flag_set[a]),
      .counts_o    (counts[a]),
      // Flags go straight out and back into the bank
      .faulty_o    (fault_map_o[a])
    );
  end

  // Software view of counters and flags
  fault_csr_bank #(
    .NUM_ALUS (NUM_ALUS)
  ) u_csr_bank (
    .csr_req_i   (csr_req_i),
    .counts_i    (counts),
    .faulty_i    (fault_map_o),
    .csr_rdata_o (csr_rdata_o),
    .cnt_we_o    (cnt_we),
    .cnt_wdata_o (cnt_wdata),
    .flag_set_o  (flag_set)
  );

endmodule

// ==== tb_alu_fault_tracker.sv ====
// Testbench for the ALU fault tracker checking CSR reads and the fault map against a model
`timescale 1ns/1ps

module tb_alu_fault_tracker
  import alu_fault_pkg::*;
();

  localparam int   NA          = 4;
  localparam int   DIV_IDX     = 8;
  localparam cnt_t THRESH      = 32'd16;
  localparam cnt_t INC         = 32'd2;
  localparam cnt_t DEC         = 32'd1;
  // About 500 cycles of tests fit well below this
  localparam int   CYCLE_LIMIT = 4000;

  logic                 clock_gated;
  logic                 rst_n;
  alu_obs_t [NA-1:0]    alu_obs_i;
  logic                 div_ready_i;
  csr_req_t             csr_req_i;
  cnt_t                 csr_rdata_o;
  class_mask_t [NA-1:0] fault_map_o;

  // Reference state
  cnt_t                 m_cnt [NA][NUM_CLASSES];
  class_mask_t [NA-1:0] m_flag;
  alu_op_t              op_table [NUM_CLASSES][4];
  int    errors = 0;
  int    err_mark = 0;
  int    tests_ok = 0;
  int    tests_bad = 0;
  int    cycles = 0;
  string test_name;

  alu_fault_tracker DUT (
    .clock_gated (clock_gated),
    .rst_n       (rst_n),
    .alu_obs_i   (alu_obs_i),
    .div_ready_i (div_ready_i),
    .csr_req_i   (csr_req_i),
    .csr_rdata_o (csr_rdata_o),
    .fault_map_o (fault_map_o)
  );

  initial clock_gated = 1'b0;
  always #2 clock_gated = ~clock_gated;

  always @(posedge clock_gated) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [CSR_ADDR_WIDTH-1:0] cnt_addr(input int a, input int c);
    return CSR_CNT_BASE + CSR_ADDR_WIDTH'(4 * c + a);
  endfunction

  function automatic logic in_class(input alu_op_t op, input int c);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < 4; k++) begin
      if (op_table[c][k] == op) hit = 1'b1;
    end
    return hit;
  endfunction

  // Expected read word for counters and the two packed map words
  function automatic cnt_t model_read(input logic [CSR_ADDR_WIDTH-1:0] addr);
    cnt_t word;
    word = '0;
    for (int a = 0; a < NA; a++) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        if (addr == cnt_addr(a, c)) word = m_cnt[a][c];
        if (addr == CSR_FMAP_LO && c < DIV_IDX) word[4*c + a] = m_flag[a][c];
      end
      if (addr == CSR_FMAP_HI) word[a] = m_flag[a][DIV_IDX];
    end
    return word;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////
  always @(posedge clock_gated or negedge rst_n) begin : ref_model
    logic ev;
    logic wr;
    logic fs;
    logic old_flag;
    if (!rst_n) begin
      m_flag = '0;
      for (int a = 0; a < NA; a++) begin
        for (int c = 0; c < NUM_CLASSES; c++) m_cnt[a][c] = '0;
      end
    end else begin
      wr = csr_req_i.we && !csr_req_i.re;
      for (int a = 0; a < NA; a++) begin
        for (int c = 0; c < NUM_CLASSES; c++) begin
          ev = alu_obs_i[a].enable && in_class(alu_obs_i[a].op, c)
               && (c != DIV_IDX || div_ready_i);
          // Map write bits only ever set flags
          fs = wr && ((c < DIV_IDX && csr_req_i.addr == CSR_FMAP_LO && csr_req_i.wdata[4*c + a])
               || (c == DIV_IDX && csr_req_i.addr == CSR_FMAP_HI && csr_req_i.wdata[a]));
          old_flag = m_flag[a][c];
          m_flag[a][c] = old_flag | fs | (ev && m_cnt[a][c] >= THRESH);
          if (wr && csr_req_i.addr == cnt_addr(a, c)) m_cnt[a][c] = csr_req_i.wdata;
          else if (old_flag) m_cnt[a][c] = '0;
          else if (ev && alu_obs_i[a].error) m_cnt[a][c] = m_cnt[a][c] + INC;
          else if (ev) m_cnt[a][c] = (m_cnt[a][c] > FLOOR) ? m_cnt[a][c] - DEC : '0;
        end
      end
    end
  end

  // Flags move on rising edges and are settled by the falling edge
  map_matches: assert property (@(negedge clock_gated) disable iff (!rst_n)
    fault_map_o === m_flag)
    else begin
      $display("Error: fault_map_o got %h expected %h", fault_map_o, m_flag);
      errors++;
    end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////
  task automatic issue(input int a, input int c, input logic err, input logic rdy);
    int k;
    k = $urandom % 4;
    @(negedge clock_gated);
    csr_req_i      = '0;
    alu_obs_i      = '0;
    div_ready_i    = rdy;
    alu_obs_i[a]   = '{1'b1, op_table[c][k], err};
  endtask

  task automatic csr_write(input logic [CSR_ADDR_WIDTH-1:0] addr, input cnt_t data);
    @(negedge clock_gated);
    alu_obs_i = '0;
    csr_req_i = '{addr, 1'b0, 1'b1, data};
  endtask

  task automatic read_check(input logic [CSR_ADDR_WIDTH-1:0] addr);
    cnt_t exp;
    @(negedge clock_gated);
    alu_obs_i = '0;
    csr_req_i = '{addr, 1'b1, 1'b0, 32'd0};
    @(negedge clock_gated);
    exp = model_read(addr);
    read_ok: assert (csr_rdata_o === exp)
      else begin
        $display("Error: csr_rdata_o at %h got %h expected %h", addr, csr_rdata_o, exp);
        errors++;
      end
    csr_req_i = '0;
  endtask

  task automatic check_all();
    for (int a = 0; a < NA; a++) begin
      for (int c = 0; c < NUM_CLASSES; c++) read_check(cnt_addr(a, c));
    end
    read_check(CSR_FMAP_LO);
    read_check(CSR_FMAP_HI);
  endtask

  // Errors until the flag sets and the counter parks at zero
  task automatic drive_to_fault(input int a, input int c);
    int n;
    csr_write(cnt_addr(a, c), '0);
    n = 0;
    while (!m_flag[a][c] && n < 20) begin
      issue(a, c, 1'b1, 1'b1);
      n++;
    end
    @(negedge clock_gated);
    alu_obs_i = '0;
    flag_seen: assert (fault_map_o[a][c] === 1'b1)
      else begin
        $display("Error: fault_map_o[%0d][%0d] got %h expected %h",
                 a, c, fault_map_o[a][c], 1'b1);
        errors++;
      end
    read_check(CSR_FMAP_LO);
    read_check(CSR_FMAP_HI);
    read_check(cnt_addr(a, c));
    repeat (3) issue(a, c, 1'b1, 1'b1);
    read_check(cnt_addr(a, c));
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    if (errors == err_mark) begin
      tests_ok++;
      $display("%s: ok", test_name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", test_name, errors - err_mark);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    void'($urandom(32'h127));
    op_table = '{
      '{ALU_ADD, ALU_SUB, ALU_SRA, ALU_SLL},
      '{ALU_AND, ALU_OR, ALU_XOR, ALU_AND},
      '{ALU_BEXT, ALU_BINS, ALU_BCLR, ALU_BSET},
      '{ALU_CNT, ALU_CLB, ALU_FF1, ALU_FL1},
      '{ALU_INS, ALU_PCKLO, ALU_SHUF, ALU_EXT},
      '{ALU_LTS, ALU_LTU, ALU_EQ, ALU_NE},
      '{ALU_ABS, ALU_CLIP, ALU_CLIPU, ALU_ABS},
      '{ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU},
      '{ALU_DIVU, ALU_DIV, ALU_REMU, ALU_REM}
    };
    rst_n       = 1'b0;
    div_ready_i = 1'b1;
    alu_obs_i   = '0;
    csr_req_i   = '0;
    repeat (8) @(posedge clock_gated);
    @(negedge clock_gated);
    rst_n = 1'b1;

    start_test("reset state");
    reset_map: assert (fault_map_o === '0)
      else begin
        $display("Error: fault_map_o got %h expected %h", fault_map_o, '0);
        errors++;
      end
    check_all();
    finish_test();

    start_test("leaky counting");
    // Divider ready toggles too, only the div/rem class may care
    repeat (160) issue($urandom % 4, $urandom % 9, ($urandom % 3) == 0, ($urandom % 4) != 0);
    // Walk one counter down through the floor
    csr_write(cnt_addr(0, 1), 32'd3);
    issue(0, 1, 1'b0, 1'b1);
    read_check(cnt_addr(0, 1));
    issue(0, 1, 1'b0, 1'b1);
    read_check(cnt_addr(0, 1));
    check_all();
    finish_test();

    start_test("threshold and sticky flag");
    drive_to_fault(2, 3);
    drive_to_fault(1, DIV_IDX);
    // Clean ops one below and then at the threshold
    csr_write(cnt_addr(0, 5), THRESH - 32'd1);
    issue(0, 5, 1'b0, 1'b1);
    csr_write(cnt_addr(0, 5), THRESH);
    issue(0, 5, 1'b0, 1'b1);
    read_check(CSR_FMAP_LO);
    read_check(cnt_addr(0, 5));
    finish_test();

    start_test("div gating");
    csr_write(cnt_addr(3, DIV_IDX), 32'd4);
    repeat (3) issue(3, DIV_IDX, 1'b1, 1'b0);
    read_check(cnt_addr(3, DIV_IDX));
    repeat (3) issue(3, DIV_IDX, 1'b1, 1'b1);
    read_check(cnt_addr(3, DIV_IDX));
    finish_test();

    start_test("csr writes");
    csr_write(cnt_addr(3, 0), 32'h9);
    read_check(cnt_addr(3, 0));
    issue(3, 0, 1'b0, 1'b1);
    read_check(cnt_addr(3, 0));
    csr_write(CSR_FMAP_LO, 32'h0000_0011);
    read_check(CSR_FMAP_LO);
    csr_write(CSR_FMAP_HI, 32'h0000_0004);
    csr_write(CSR_FMAP_LO, 32'h0);
    csr_write(CSR_FMAP_HI, 32'h0);
    read_check(CSR_FMAP_LO);
    read_check(CSR_FMAP_HI);
    // Read and write together perform only the read
    @(negedge clock_gated);
    alu_obs_i = '0;
    csr_req_i = '{cnt_addr(3, 0), 1'b1, 1'b1, 32'h55};
    @(negedge clock_gated);
    both_read: assert (csr_rdata_o === model_read(cnt_addr(3, 0)))
      else begin
        $display("Error: csr_rdata_o got %h expected %h", csr_rdata_o,
                 model_read(cnt_addr(3, 0)));
        errors++;
      end
    csr_req_i = '0;
    read_check(cnt_addr(3, 0));
    read_check(12'h000);
    read_check(CSR_FMAP_HI + 12'd1);
    // Without a read strobe the bus stays quiet
    csr_req_i = '{cnt_addr(3, 0), 1'b0, 1'b0, 32'd0};
    @(negedge clock_gated);
    idle_read: assert (csr_rdata_o === '0)
      else begin
        $display("Error: csr_rdata_o got %h expected %h", csr_rdata_o, 32'd0);
        errors++;
      end
    csr_req_i = '0;
    check_all();
    finish_test();

    $display("Summary: %0d tests clean, %0d tests with errors, %0d errors",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== alu_fault_tracker.f ====
alu_fault_pkg.sv
alu_op_classifier.sv
subunit_err_counter.sv
alu_health_monitor.sv
fault_csr_bank.sv
alu_fault_tracker.sv
tb_alu_fault_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fault tracker testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_alu_fault_tracker \
  -f alu_fault_tracker.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
